// ==== hdl/rv_isa_pkg.sv ====
// RV32I instruction-set encodings
// Field widths, major opcodes, funct3/funct7 codes
// Immediate format selector and basic word types
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;

    typedef logic [XLEN-1:0]      instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes
    typedef enum logic [OPCODE_W-1:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    //////////////////////////////////////////////////////////////////////
    // funct3 groups
    typedef enum logic [FUNCT3_W-1:0] {
        F3_ADD  = 3'b000,   // ADD/SUB
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,   // SRL/SRA
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    typedef enum logic [FUNCT3_W-1:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    typedef enum logic [FUNCT3_W-1:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } load_f3_e;

    typedef enum logic [FUNCT3_W-1:0] {
        F3_SB = 3'b000,
        F3_SH = 3'b001,
        F3_SW = 3'b010
    } store_f3_e;

    localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'b0100000;   // SUB, SRA, SRAI

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_fmt_e;

endpackage

`default_nettype wire

// ==== hdl/core_ctrl_pkg.sv ====
// Datapath control vocabulary
// ALU op, compare type and write-back select encodings
// Packed decode result struct
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_SLL = 4'd2,
        ALU_SRL = 4'd3,
        ALU_SRA = 4'd4,
        ALU_XOR = 4'd5,
        ALU_OR  = 4'd6,
        ALU_AND = 4'd7
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_UN  = 3'd0,     // Unconditional
        CMP_EQ  = 3'd1,
        CMP_NE  = 3'd2,
        CMP_LT  = 3'd3,
        CMP_GE  = 3'd4,
        CMP_LTU = 3'd5,
        CMP_GEU = 3'd6
    } cmp_type_e;

    typedef enum logic [2:0] {
        RF_DIN_IMM = 3'd0,
        RF_DIN_PC4 = 3'd1,  // Link address
        RF_DIN_ALU = 3'd2,
        RF_DIN_CMP = 3'd3,
        RF_DIN_MEM = 3'd4
    } rf_din_sel_e;

    //////////////////////////////////////////////////////////////////////
    // All-zero decode result is a harmless bubble
    typedef struct packed {
        rv_isa_pkg::reg_idx_t      rd;
        rv_isa_pkg::reg_idx_t      rs1;
        rv_isa_pkg::reg_idx_t      rs2;
        logic [rv_isa_pkg::XLEN-1:0] imm;
        logic                      jump_en;
        cmp_type_e                 cmp_type;
        logic                      rf_we;
        rf_din_sel_e               rf_din_sel;
        logic                      a_op_sel;      // 1: PC
        logic                      b_op_sel;      // 1: immediate
        logic                      cmp_b_op_sel;  // 1: immediate
        alu_op_e                   alu_op;
        logic [2:0]                mem_width;
        logic                      mem_access;
        logic                      mem_we;
        logic                      illegal;
    } decode_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/rv_imm_gen.sv ====
// Immediate generator
// Sign-extended RV32I immediate for the I, S, B, U and J formats
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen
    import rv_isa_pkg::*;
(
    input  wire instr_t          instr_i,
    input  wire imm_fmt_e        imm_fmt_i,
    output logic [XLEN-1:0]      imm_o
);

    always_comb
    begin
        case (imm_fmt_i)
            IMM_I:
                imm_o = {{21{instr_i[31]}}, instr_i[30:20]};
            IMM_S:
                imm_o = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
            IMM_B:
                imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};                              // Halfword offset
            IMM_U:
                imm_o = {instr_i[31:12], 12'd0};
            IMM_J:
                imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            default:
                imm_o = '0;                                                 // Unknown format
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/rv_ctrl_decode.sv ====
// RV32I control decoder
// Opcode/funct table to datapath control fields, immediate format
// and illegal-instruction flag
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_decode
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  wire instr_t   instr_i,
    output decode_ctrl_t  ctrl_o,
    output imm_fmt_e      imm_fmt_o
);

    rv_opcode_e           opcode;
    logic [FUNCT3_W-1:0]  funct3;
    logic [FUNCT7_W-1:0]  funct7;

    assign opcode = rv_opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb
    begin
        ctrl_o            = '0;
        ctrl_o.rd         = instr_i[11:7];
        ctrl_o.rs1        = instr_i[19:15];
        ctrl_o.rs2        = instr_i[24:20];
        ctrl_o.cmp_type   = CMP_UN;
        ctrl_o.rf_din_sel = RF_DIN_IMM;
        ctrl_o.alu_op     = ALU_ADD;
        ctrl_o.mem_width  = funct3;
        imm_fmt_o         = IMM_U;

        case (opcode)
            OPC_LUI:
            begin
                ctrl_o.rf_we = 1'b1;
            end

            OPC_AUIPC:
            begin
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = RF_DIN_ALU;
                ctrl_o.a_op_sel   = 1'b1;                       // PC + imm
                ctrl_o.b_op_sel   = 1'b1;
            end

            OPC_JAL:
            begin
                ctrl_o.jump_en    = 1'b1;
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = RF_DIN_PC4;
                ctrl_o.a_op_sel   = 1'b1;
                ctrl_o.b_op_sel   = 1'b1;
                imm_fmt_o         = IMM_J;
            end

            OPC_JALR:
            begin
                ctrl_o.jump_en    = 1'b1;
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = RF_DIN_PC4;
                ctrl_o.b_op_sel   = 1'b1;                       // rs1 + imm
                ctrl_o.illegal    = (funct3 != 3'b000);
                imm_fmt_o         = IMM_I;
            end

            OPC_BRANCH:
            begin
                ctrl_o.jump_en  = 1'b1;
                ctrl_o.a_op_sel = 1'b1;                         // Target is PC + imm
                ctrl_o.b_op_sel = 1'b1;
                imm_fmt_o       = IMM_B;
                case (funct3)
                    F3_BEQ:  ctrl_o.cmp_type = CMP_EQ;
                    F3_BNE:  ctrl_o.cmp_type = CMP_NE;
                    F3_BLT:  ctrl_o.cmp_type = CMP_LT;
                    F3_BGE:  ctrl_o.cmp_type = CMP_GE;
                    F3_BLTU: ctrl_o.cmp_type = CMP_LTU;
                    F3_BGEU: ctrl_o.cmp_type = CMP_GEU;
                    default: ctrl_o.illegal  = 1'b1;
                endcase
            end

            OPC_LOAD:
            begin
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = RF_DIN_MEM;
                ctrl_o.b_op_sel   = 1'b1;
                ctrl_o.mem_access = 1'b1;
                ctrl_o.illegal    = !(funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
                imm_fmt_o         = IMM_I;
            end

            OPC_STORE:
            begin
                ctrl_o.b_op_sel   = 1'b1;
                ctrl_o.mem_access = 1'b1;
                ctrl_o.mem_we     = 1'b1;
                ctrl_o.illegal    = !(funct3 inside {F3_SB, F3_SH, F3_SW});
                imm_fmt_o         = IMM_S;
            end

            //////////////////////////////////////////////////////////////////////
            // Register-immediate ALU group
            OPC_OP_IMM:
            begin
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = RF_DIN_ALU;
                ctrl_o.b_op_sel   = 1'b1;
                imm_fmt_o         = IMM_I;
                case (funct3)
                    F3_ADD:  ctrl_o.alu_op = ALU_ADD;
                    F3_XOR:  ctrl_o.alu_op = ALU_XOR;
                    F3_OR:   ctrl_o.alu_op = ALU_OR;
                    F3_AND:  ctrl_o.alu_op = ALU_AND;
                    F3_SLT, F3_SLTU:
                    begin
                        ctrl_o.rf_din_sel   = RF_DIN_CMP;
                        ctrl_o.b_op_sel     = 1'b0;
                        ctrl_o.cmp_b_op_sel = 1'b1;
                        ctrl_o.cmp_type     = (funct3 == F3_SLT) ? CMP_LT : CMP_LTU;
                    end
                    F3_SLL:
                    begin
                        ctrl_o.alu_op  = ALU_SLL;
                        ctrl_o.illegal = (funct7 != FUNCT7_BASE);
                    end
                    default:                                    // SRLI/SRAI
                    begin
                        ctrl_o.alu_op  = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                        ctrl_o.illegal = (funct7 != FUNCT7_BASE) && (funct7 != FUNCT7_ALT);
                    end
                endcase
            end

            // Register-register group without the M extension
            OPC_OP:
            begin
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = RF_DIN_ALU;
                if (funct7 == FUNCT7_BASE)
                begin
                    case (funct3)
                        F3_ADD:  ctrl_o.alu_op = ALU_ADD;
                        F3_SLL:  ctrl_o.alu_op = ALU_SLL;
                        F3_XOR:  ctrl_o.alu_op = ALU_XOR;
                        F3_SR:   ctrl_o.alu_op = ALU_SRL;
                        F3_OR:   ctrl_o.alu_op = ALU_OR;
                        F3_AND:  ctrl_o.alu_op = ALU_AND;
                        default:                                // SLT/SLTU
                        begin
                            ctrl_o.rf_din_sel = RF_DIN_CMP;
                            ctrl_o.cmp_type   = (funct3 == F3_SLT) ? CMP_LT : CMP_LTU;
                        end
                    endcase
                end
                else if (funct7 == FUNCT7_ALT && funct3 == F3_ADD)
                    ctrl_o.alu_op = ALU_SUB;
                else if (funct7 == FUNCT7_ALT && funct3 == F3_SR)
                    ctrl_o.alu_op = ALU_SRA;
                else
                    ctrl_o.illegal = 1'b1;
            end

            OPC_SYSTEM: ctrl_o.illegal = 1'b1;                  // No CSR or trap support
            default:    ctrl_o.illegal = 1'b1;
        endcase

        // A bad instruction must not change architectural state
        if (ctrl_o.illegal)
        begin
            ctrl_o.rf_we      = 1'b0;
            ctrl_o.mem_we     = 1'b0;
            ctrl_o.mem_access = 1'b0;
            ctrl_o.jump_en    = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
// Registered RV32I decode stage
// Control table and immediate generator in parallel
// Result register loaded one cycle after the input strobe
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire            instr_valid_i,
    input  wire instr_t    instr_i,
    output logic           dec_valid_o,
    output decode_ctrl_t   dec_o
);

    decode_ctrl_t      ctrl;
    decode_ctrl_t      dec_next;
    imm_fmt_e          imm_fmt;
    logic [XLEN-1:0]   imm;

    rv_ctrl_decode u_ctrl_decode (
        .instr_i    (instr_i),
        .ctrl_o     (ctrl),
        .imm_fmt_o  (imm_fmt)
    );

    rv_imm_gen u_imm_gen (
        .instr_i    (instr_i),
        .imm_fmt_i  (imm_fmt),
        .imm_o      (imm)
    );

    always_comb
    begin
        dec_next     = ctrl;
        dec_next.imm = imm;     // Table leaves imm at zero
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            dec_valid_o <= 1'b0;
            dec_o       <= '0;
        end
        else
        begin
            dec_valid_o <= instr_valid_i;   // One-cycle pulse per strobe
            if (instr_valid_i)
                dec_o <= dec_next;          // Held until next strobe
        end
    end

endmodule

`default_nettype wire

// ==== verif/instr_decoder_sva.sv ====
// Assertions for the registered decode stage
// Strobe latency and side-effect-free illegal results
// Bound into instr_decoder
`timescale 1ns/1ps
`default_nettype none

module instr_decoder_sva
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input wire               clk,
    input wire               rst_n_i,
    input wire               instr_valid_i,
    input wire               dec_valid_o,
    input wire decode_ctrl_t dec_o
);

    a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        instr_valid_i |=> dec_valid_o)
        else $error("dec_valid_o missing one cycle after a strobe");

    a_no_orphan: assert property (@(posedge clk) disable iff (!rst_n_i)
        !instr_valid_i |=> !dec_valid_o)
        else $error("dec_valid_o high without a strobe the cycle before");

    // No state change from a bad instruction
    a_illegal_safe: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dec_valid_o && dec_o.illegal) |->
            !(dec_o.rf_we || dec_o.mem_we || dec_o.mem_access || dec_o.jump_en))
        else $error("illegal decode result with an enable set");

endmodule

bind instr_decoder instr_decoder_sva u_sva (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .dec_valid_o   (dec_valid_o),
    .dec_o         (dec_o)
);

`default_nettype wire

// ==== verif/tb_instr_decoder.sv ====
// Testbench for the registered RV32I decode stage
// Random instruction stimulus, reference decode model, result queue
// and per-test reporting
`timescale 1ns/1ps
`default_nettype none

module tb_instr_decoder
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
();

    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CYCLES   = 10;
    localparam int LAT_COUNT     = 40;
    localparam int RAND_COUNT    = 120;
    localparam int MAX_GAP       = 2;
    localparam int DRAIN_CYCLES  = 4;
    localparam int NUM_TESTS     = 6;
    localparam int TOTAL_STROBES = LAT_COUNT + 4 * RAND_COUNT;
    localparam int TOTAL_IDLE    = RESET_CYCLES + IDLE_CYCLES + LAT_COUNT * MAX_GAP
                                   + NUM_TESTS * DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = (TOTAL_STROBES + TOTAL_IDLE) * 2 + 100;

    localparam int GRP_ANY     = 0;
    localparam int GRP_ALU     = 1;
    localparam int GRP_FLOW    = 2;
    localparam int GRP_ILLEGAL = 3;

    logic           clk = 1'b0;
    logic           rst_n_i;
    logic           instr_valid_i;
    instr_t         instr_i;
    logic           dec_valid_o;
    decode_ctrl_t   dec_o;

    decode_ctrl_t   exp_q[$];
    decode_ctrl_t   exp_dec;
    decode_ctrl_t   last_dec = '0;
    logic           strobe_seen = 1'b0;
    string          test_name = "none";
    int             seed;
    int             err_count    = 0;
    int             check_count  = 0;
    int             tests_run    = 0;
    int             tests_failed = 0;
    int             cycle_count  = 0;

    instr_decoder uut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference decode model
    function automatic decode_ctrl_t expected_decode(input instr_t w);
        decode_ctrl_t d;
        logic [6:0]   opc;
        logic [2:0]   f3;
        logic [6:0]   f7;
        logic         bad;
        opc          = w[6:0];
        f3           = w[14:12];
        f7           = w[31:25];
        bad          = 1'b0;
        d            = '0;
        d.rd         = w[11:7];
        d.rs1        = w[19:15];
        d.rs2        = w[24:20];
        d.cmp_type   = CMP_UN;
        d.rf_din_sel = RF_DIN_IMM;
        d.alu_op     = ALU_ADD;
        d.mem_width  = f3;
        d.imm        = {w[31:12], 12'h000};                        // U format by default
        case (opc)
            7'b0110111:
                d.rf_we = 1'b1;
            7'b0010111:
            begin
                d.rf_we      = 1'b1;
                d.rf_din_sel = RF_DIN_ALU;
                d.a_op_sel   = 1'b1;
                d.b_op_sel   = 1'b1;
            end
            7'b1101111:
            begin
                d.jump_en    = 1'b1;
                d.rf_we      = 1'b1;
                d.rf_din_sel = RF_DIN_PC4;
                d.a_op_sel   = 1'b1;
                d.b_op_sel   = 1'b1;
                d.imm        = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100111:
            begin
                d.jump_en    = 1'b1;
                d.rf_we      = 1'b1;
                d.rf_din_sel = RF_DIN_PC4;
                d.b_op_sel   = 1'b1;
                d.imm        = {{20{w[31]}}, w[31:20]};
                bad          = (f3 != 3'b000);
            end
            7'b1100011:
            begin
                d.jump_en  = 1'b1;
                d.a_op_sel = 1'b1;
                d.b_op_sel = 1'b1;
                d.imm      = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                case (f3)
                    3'b000:  d.cmp_type = CMP_EQ;
                    3'b001:  d.cmp_type = CMP_NE;
                    3'b100:  d.cmp_type = CMP_LT;
                    3'b101:  d.cmp_type = CMP_GE;
                    3'b110:  d.cmp_type = CMP_LTU;
                    3'b111:  d.cmp_type = CMP_GEU;
                    default: bad = 1'b1;
                endcase
            end
            7'b0000011:
            begin
                d.rf_we      = 1'b1;
                d.rf_din_sel = RF_DIN_MEM;
                d.b_op_sel   = 1'b1;
                d.mem_access = 1'b1;
                d.imm        = {{20{w[31]}}, w[31:20]};
                bad          = (f3 == 3'b011) || (f3 > 3'b101);
            end
            7'b0100011:
            begin
                d.b_op_sel   = 1'b1;
                d.mem_access = 1'b1;
                d.mem_we     = 1'b1;
                d.imm        = {{20{w[31]}}, w[31:25], w[11:7]};
                bad          = (f3 > 3'b010);
            end
            7'b0010011:
            begin
                d.rf_we      = 1'b1;
                d.rf_din_sel = RF_DIN_ALU;
                d.imm        = {{20{w[31]}}, w[31:20]};
                if (f3 == 3'b010 || f3 == 3'b011)
                begin
                    d.rf_din_sel   = RF_DIN_CMP;                   // SLTI, SLTIU
                    d.cmp_b_op_sel = 1'b1;
                    d.cmp_type     = f3[0] ? CMP_LTU : CMP_LT;
                end
                else
                begin
                    d.b_op_sel = 1'b1;
                    case (f3)
                        3'b100:  d.alu_op = ALU_XOR;
                        3'b110:  d.alu_op = ALU_OR;
                        3'b111:  d.alu_op = ALU_AND;
                        3'b001:
                        begin
                            d.alu_op = ALU_SLL;
                            bad      = (f7 != 7'b0000000);
                        end
                        3'b101:
                        begin
                            d.alu_op = (f7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
                            bad      = (f7 != 7'b0000000) && (f7 != 7'b0100000);
                        end
                        default: d.alu_op = ALU_ADD;
                    endcase
                end
            end
            7'b0110011:
            begin
                d.rf_we      = 1'b1;
                d.rf_din_sel = RF_DIN_ALU;
                if (f7 == 7'b0000000)
                begin
                    case (f3)
                        3'b001:  d.alu_op = ALU_SLL;
                        3'b100:  d.alu_op = ALU_XOR;
                        3'b101:  d.alu_op = ALU_SRL;
                        3'b110:  d.alu_op = ALU_OR;
                        3'b111:  d.alu_op = ALU_AND;
                        3'b010:
                        begin
                            d.rf_din_sel = RF_DIN_CMP;
                            d.cmp_type   = CMP_LT;
                        end
                        3'b011:
                        begin
                            d.rf_din_sel = RF_DIN_CMP;
                            d.cmp_type   = CMP_LTU;
                        end
                        default: d.alu_op = ALU_ADD;
                    endcase
                end
                else if (f7 == 7'b0100000 && f3 == 3'b000)
                    d.alu_op = ALU_SUB;
                else if (f7 == 7'b0100000 && f3 == 3'b101)
                    d.alu_op = ALU_SRA;
                else
                    bad = 1'b1;
            end
            default:
                bad = 1'b1;                                         // SYSTEM and unknown
        endcase
        if (bad)
        begin
            d.rf_we      = 1'b0;
            d.mem_we     = 1'b0;
            d.mem_access = 1'b0;
            d.jump_en    = 1'b0;
        end
        d.illegal = bad;
        return d;
    endfunction

    function automatic logic [6:0] opcode_at(input int idx);
        case (idx)
            0:       return 7'b0110111;
            1:       return 7'b0010111;
            2:       return 7'b1101111;
            3:       return 7'b1100111;
            4:       return 7'b1100011;
            5:       return 7'b0000011;
            6:       return 7'b0100011;
            7:       return 7'b0010011;
            default: return 7'b0110011;
        endcase
    endfunction

    function automatic logic is_legal_opcode(input logic [6:0] opc);
        return opc inside {7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
                           7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    task automatic make_instr(input int group, output instr_t w);
        int pick;
        w    = $random(seed);
        pick = $unsigned($random(seed)) % 9;
        case (group)
            GRP_ANY:
                w[6:0] = opcode_at(pick);
            GRP_ALU:
            begin
                if (pick[0])
                begin
                    w[6:0] = 7'b0010011;
                    if (w[14:12] == 3'b001)
                        w[31:25] = 7'b0000000;
                    else if (w[14:12] == 3'b101)
                        w[31:25] = w[30] ? 7'b0100000 : 7'b0000000;
                end
                else
                begin
                    w[6:0]   = 7'b0110011;
                    w[31:25] = (w[30] && (w[14:12] == 3'b000 || w[14:12] == 3'b101))
                               ? 7'b0100000 : 7'b0000000;
                end
            end
            GRP_FLOW:
            begin
                case (pick % 5)
                    0:
                        w[6:0] = 7'b1101111;
                    1:
                    begin
                        w[6:0]   = 7'b1100111;
                        w[14:12] = 3'b000;
                    end
                    2:
                    begin
                        w[6:0] = 7'b1100011;
                        if (w[14:13] == 2'b01)
                            w[14] = 1'b1;                           // 010/011 to 110/111
                    end
                    3:
                    begin
                        w[6:0] = 7'b0000011;
                        if (w[14:12] == 3'b011 || w[14:13] == 2'b11)
                            w[14:12] = w[14:12] - 3'd2;
                    end
                    default:
                    begin
                        w[6:0]   = 7'b0100011;
                        w[14:12] = w[14:12] % 3'd3;
                    end
                endcase
            end
            default:
            begin
                case (pick % 6)
                    0:
                    begin
                        while (is_legal_opcode(w[6:0]))
                            w = $random(seed);
                    end
                    1:
                        w[6:0] = 7'b1110011;
                    2:
                    begin
                        w[6:0]   = 7'b0110011;
                        w[31:25] = {1'b0, w[30], 5'b00001};         // M extension
                    end
                    3:
                    begin
                        w[6:0]   = 7'b0000011;
                        w[14:12] = w[13] ? {2'b11, w[12]} : 3'b011;
                    end
                    4:
                    begin
                        w[6:0] = 7'b0100011;
                        if (w[14:12] < 3'd3)
                            w[14:12] = w[14:12] + 3'd3;
                    end
                    default:
                    begin
                        w[6:0]   = 7'b1100011;
                        w[14:12] = {2'b01, w[12]};
                    end
                endcase
            end
        endcase
    endtask

    task automatic send_instr(input instr_t w);
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= w;
        exp_q.push_back(expected_decode(w));
    endtask

    task automatic go_idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            instr_valid_i <= 1'b0;
            instr_i       <= $random(seed);                          // Ignored without a strobe
        end
    endtask

    task automatic report_test(input string name, input int errs);
        string verdict;
        verdict = (errs == 0) ? "ok" : "FAILED";
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %s: %s, %0d errors", name, verdict, errs);
    endtask

    task automatic check_reset_idle();
        int           errs_before;
        decode_ctrl_t zero_dec;
        zero_dec    = '0;
        test_name   = "reset_idle";
        errs_before = err_count;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_count++;
        if (dec_o !== zero_dec)
        begin
            $display("[FAIL] %s expected %h actual %h", test_name, zero_dec, dec_o);
            err_count++;
        end
        go_idle(IDLE_CYCLES);                                       // Monitor checks valid low
        report_test(test_name, err_count - errs_before);
    endtask

    task automatic run_test(input string name, input int group, input int count,
                            input int max_gap);
        int     errs_before;
        int     gap;
        instr_t w;
        test_name   = name;
        errs_before = err_count;
        for (int i = 0; i < count; i++)
        begin
            make_instr(group, w);
            send_instr(w);
            gap = (max_gap > 0) ? $unsigned($random(seed)) % (max_gap + 1) : 0;
            if (gap > 0)
                go_idle(gap);
        end
        go_idle(1);
        while (exp_q.size() != 0)
            @(posedge clk);
        @(negedge clk);
        report_test(name, err_count - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor at the falling edge
    always @(negedge clk)
    begin
        if (!rst_n_i)
        begin
            if (dec_valid_o !== 1'b0)
            begin
                $display("ERROR: dec_valid_o is high during reset in test %s", test_name);
                err_count++;
            end
        end
        else
        begin
            if (dec_valid_o !== strobe_seen)
            begin
                $display("ERROR: dec_valid_o does not follow the strobe by one cycle in %s",
                         test_name);
                err_count++;
            end
            if (dec_valid_o === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("ERROR: dec_valid_o pulsed with no decode pending in %s",
                             test_name);
                    err_count++;
                end
                else
                begin
                    exp_dec  = exp_q.pop_front();
                    last_dec = exp_dec;
                    check_count++;
                    if (dec_o !== exp_dec)
                    begin
                        $display("[FAIL] %s expected %h actual %h", test_name, exp_dec, dec_o);
                        err_count++;
                    end
                end
            end
            else if (dec_o !== last_dec)                            // Held between results
            begin
                $display("[FAIL] %s expected %h actual %h", test_name, last_dec, dec_o);
                err_count++;
            end
        end
        strobe_seen = instr_valid_i;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("ERROR: timeout, the run exceeded %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial
    begin
        seed          = 72229;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        check_reset_idle();
        run_test("latency_order", GRP_ANY, LAT_COUNT, MAX_GAP);
        run_test("immediates", GRP_ANY, RAND_COUNT, 0);
        run_test("alu_cmp", GRP_ALU, RAND_COUNT, 0);
        run_test("flow_mem", GRP_FLOW, RAND_COUNT, 0);
        run_test("illegal", GRP_ILLEGAL, RAND_COUNT, 0);
        $display("summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0 && tests_failed == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/rv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/rv_imm_gen.sv
hdl/rv_ctrl_decode.sv
hdl/instr_decoder.sv
verif/instr_decoder_sva.sv
verif/tb_instr_decoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_instr_decoder \
    -f files.f -o tb_instr_decoder > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_instr_decoder > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"
